//--- sources.f
hdl/calc_pkg.sv
hdl/keypad_scanner.sv
hdl/key_decoder.sv
hdl/calc_core.sv
hdl/calc_top.sv
tb/tb_clock_gen.sv
tb/keypad_model.sv
tb/tb_calc_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the keypad calculator testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_calc_top -f sources.f -o sim_calc

./obj_dir/sim_calc | tee sim.log

# the log decides the result
if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without failures"

//--- tb/calc_trace.txt
// test code hold bounce ack_delay expected, all hex, hold and delay in clock cycles
// expected is the 16-bit display after the key, test number ffff ends the list
2 0 20 0 2 0001
2 1 20 0 2 000c
2 2 20 0 2 007b
2 a 20 0 2 04d7
2 d 20 0 2 3066
2 e 20 0 2 0000
3 0 20 0 2 0001
3 1 20 0 2 000c
3 3 20 0 2 000c
3 8 20 0 2 0007
3 7 20 0 2 0013
3 4 20 0 2 0004
3 b 20 0 2 000f
3 2 20 0 2 0003
3 c 20 0 2 002d
3 f 20 0 2 ffd3
3 e 20 0 2 0000
4 2 20 0 2 0003
4 d 20 0 2 001e
4 d 20 0 2 012c
4 b 20 0 2 012c
4 2 20 0 2 0003
4 d 20 0 2 001e
4 d 20 0 2 012c
4 c 20 0 2 5f90
5 e c8 3 2 0000
5 5 12c 4 2 0005
6 9 20 0 12c 003a
6 0 20 0 2 0245
6 3 20 0 2 0245
ffff 0 0 0 0 0

//--- tb/tb_calc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_calc_top import calc_pkg::*; ();

    localparam int MAX_KEYS   = 64;
    localparam int WAIT_LIMIT = 2000;                  // cycles per wait
    localparam int IN_FLIGHT  = 3;                     // scanner, decoder, core

    logic              clk;
    logic              nRST;
    logic [3:0]        row;
    logic [3:0]        col;
    logic [DATA_W-1:0] display;
    logic              disp_req;
    logic              disp_ack;
    logic              key_down;                       // contact closed
    key_code_t         key;
    logic [15:0]       trace_mem [0:6*MAX_KEYS-1];     // six fields per key
    int                n_keys;
    int                pressed;                        // keys started
    int                checked;                        // displays consumed
    int                errors;
    int                test_errs;
    int                tests_ok;
    int                tests_bad;
    logic              hung;                           // a wait ran out

    tb_clock_gen u_clk (.clk(clk), .nRST(nRST));

    keypad_model u_pad (.col(col), .pressed(key_down), .key(key), .row(row));

    calc_top u_dut (
        .clk      (clk),
        .nRST     (nRST),
        .row      (row),
        .col      (col),
        .display  (display),
        .disp_req (disp_req),
        .disp_ack (disp_ack)
    );

    function automatic int field(input int idx, input int f);
        return int'(trace_mem[6*idx+f]);
    endfunction

    task automatic count_error();
        errors++;
        test_errs++;
    endtask

    task automatic finish_test(input int num);
        if (test_errs == 0) begin
            $display("test %0d: ok", num);
            tests_ok++;
        end else begin
            $display("test %0d: %0d errors", num, test_errs);
            tests_bad++;
        end
        test_errs = 0;
    endtask

    // sampled on falling edges away from DUT updates
    task automatic wait_disp(input logic level, input string what);
        int t;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (disp_req !== level && t < WAIT_LIMIT && !hung);
        if (disp_req !== level && !hung)
            $display("timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
        if (disp_req !== level)
            hung = 1'b1;
    endtask

    task automatic press_key(input key_code_t code, input int hold, input int bounce);
        int gap;
        @(posedge clk);
        key      <= code;
        key_down <= 1'b1;
        for (int b = 0; b < 2 * bounce; b++) begin     // chatter that ends closed
            gap = 1 + int'($urandom % (DEBOUNCE_CYCLES - 1));
            repeat (gap) @(posedge clk);
            key_down <= ~key_down;
        end
        repeat (hold) @(posedge clk);
        key_down <= 1'b0;
        repeat (2 * DEBOUNCE_CYCLES) @(posedge clk);   // scanner sees key up
    endtask

    task automatic press_all();
        int t;
        for (int i = 0; i < n_keys && !hung; i++) begin
            t = 0;
            while (pressed - checked >= IN_FLIGHT && t < WAIT_LIMIT && !hung) begin
                @(negedge clk);                        // hold off while the pipeline is full
                t++;
            end
            if (pressed - checked < IN_FLIGHT) begin
                pressed++;
                press_key(key_code_t'(field(i, 1)), field(i, 2), field(i, 3));
            end else begin
                if (!hung)
                    $display("timeout: pipeline never freed a slot for key %0d", i);
                hung = 1'b1;
            end
        end
    endtask

    task automatic check_all();
        logic [DATA_W-1:0] expected;
        for (int i = 0; i < n_keys && !hung; i++) begin
            wait_disp(1'b1, "disp_req rising");
            if (!hung) begin
                if (i >= pressed) begin
                    $display("a display update at %0d ns had no key press behind it", $time);
                    count_error();
                end
                expected = trace_mem[6*i+5];
                if (display !== expected) begin
                    $display("error at %0d ns: display expected %0d got %0d",
                             $time, $signed(expected), $signed(display));
                    count_error();
                end
                repeat (field(i, 4) + 1) @(posedge clk);   // slow consumer
                disp_ack <= 1'b1;
                wait_disp(1'b0, "disp_req falling");
                @(posedge clk);
                disp_ack <= 1'b0;
                checked++;
                if (i == n_keys - 1 || field(i + 1, 0) != field(i, 0))
                    finish_test(field(i, 0));
            end
        end
    endtask

    initial begin
        int t;
        void'($urandom(32'h2dcd_abb2));                // one seed per run
        disp_ack  = 1'b0;
        key_down  = 1'b0;
        key       = '0;
        pressed   = 0;
        checked   = 0;
        errors    = 0;
        test_errs = 0;
        tests_ok  = 0;
        tests_bad = 0;
        hung      = 1'b0;
        $readmemh("tb/calc_trace.txt", trace_mem);
        n_keys = 0;
        while (n_keys < MAX_KEYS && trace_mem[6*n_keys] != 16'hFFFF)
            n_keys++;

        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (nRST !== 1'b1 && t < 10);
        if (nRST !== 1'b1) begin
            $display("timeout: reset was never released");
            hung = 1'b1;
        end else if (col !== 4'b1110) begin
            $display("error at %0d ns: col expected 1110 got %b", $time, col);
            count_error();
        end

        t = 0;                                         // idle after reset
        do begin
            @(negedge clk);
            t++;
        end while (disp_req === 1'b0 && display === '0 && t < 50);
        if (disp_req !== 1'b0) begin
            $display("disp_req rose at %0d ns with no key pressed", $time);
            count_error();
        end
        if (display !== '0) begin
            $display("error at %0d ns: display expected 0 got %0d", $time, $signed(display));
            count_error();
        end
        finish_test(1);

        fork
            press_all();
            check_all();
        join

        if (!hung) begin
            t = 0;                                     // stray updates after last key
            do begin
                @(negedge clk);
                t++;
            end while (disp_req === 1'b0 && t < 100);
            if (disp_req !== 1'b0) begin
                $display("display updated at %0d ns after the last key", $time);
                errors++;
            end
        end

        $display("summary: %0d tests clean, %0d tests with errors, %0d errors",
                 tests_ok, tests_bad, errors);
        if (errors == 0 && !hung)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/keypad_model.sv
`timescale 1ns/1ps
`default_nettype none

module keypad_model import calc_pkg::*; (
    input  logic       [3:0] col,      // active low drive from scanner
    input  logic             pressed,  // switch contact closed
    input  key_code_t        key,      // row*4 + col of the pressed key
    output logic       [3:0] row       // active low, pulled up
);

    // closed switch shorts its row to its column
    always_comb begin
        row = 4'hF;                    // pull-ups
        if (pressed && !col[key[1:0]])
            row[key[3:2]] = 1'b0;
    end

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic nRST
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;        // 100 ns period
    end

    initial begin
        nRST = 1'b0;                   // held for two rising edges
        repeat (2) @(posedge clk);
        nRST <= 1'b1;
    end

endmodule

`default_nettype wire

//--- hdl/calc_top.sv
`timescale 1ns/1ps
`default_nettype none

module calc_top import calc_pkg::*; (
    input  logic              clk,
    input  logic              nRST,
    input  logic [3:0]        row,       // keypad rows, active low
    output logic [3:0]        col,       // keypad columns, active low
    output logic [DATA_W-1:0] display,
    output logic              disp_req,
    input  logic              disp_ack
);

    logic       key_req;     // scanner -> decoder
    logic       key_ack;
    key_code_t  key_code;
    logic       ev_req;      // decoder -> core
    key_event_t ev;
    logic       ev_ack;

    keypad_scanner u_scan (
        .clk      (clk),
        .nRST     (nRST),
        .row      (row),
        .col      (col),
        .key_req  (key_req),
        .key_ack  (key_ack),
        .key_code (key_code)
    );

    key_decoder u_dec (
        .clk      (clk),
        .nRST     (nRST),
        .key_req  (key_req),
        .key_code (key_code),
        .key_ack  (key_ack),
        .ev_req   (ev_req),
        .ev       (ev),
        .ev_ack   (ev_ack)
    );

    calc_core u_core (
        .clk      (clk),
        .nRST     (nRST),
        .ev_req   (ev_req),
        .ev       (ev),
        .ev_ack   (ev_ack),
        .display  (display),
        .disp_req (disp_req),
        .disp_ack (disp_ack)
    );

endmodule

`default_nettype wire

//--- hdl/calc_core.sv
`timescale 1ns/1ps
`default_nettype none

module calc_core import calc_pkg::*; (
    input  logic              clk,
    input  logic              nRST,
    input  logic              ev_req,
    input  key_event_t        ev,
    output logic              ev_ack,
    output logic [DATA_W-1:0] display,
    output logic              disp_req,
    input  logic              disp_ack
);

    typedef enum logic [1:0] {
        READY,        // free to take an event
        SHOW,         // disp_req up until ack
        DRAIN         // waiting for disp_ack low
    } core_state_e;

    core_state_e              state;
    logic signed [DATA_W-1:0] acc;
    logic signed [DATA_W-1:0] entry;
    op_e                      pending;      // operator waiting for its right operand
    logic                     after_eq;     // last key was equal

    logic signed [DATA_W-1:0] entry_base;
    logic signed [DATA_W-1:0] resolved;     // acc with pending op applied
    logic signed [DATA_W-1:0] acc_n;
    logic signed [DATA_W-1:0] entry_n;
    logic [DATA_W-1:0]        disp_n;
    op_e                      pending_n;
    logic                     accept;

    function automatic logic signed [DATA_W-1:0] alu(
        input logic signed [DATA_W-1:0] a,
        input op_e                      op,
        input logic signed [DATA_W-1:0] b
    );
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_MUL:  return a * b;          // low half kept so it wraps
            default: return b;              // nothing pending
        endcase
    endfunction

    assign accept     = (state == READY) && ev_req && !ev_ack && !disp_ack;
    assign entry_base = after_eq ? '0 : entry;   // new number after equal
    assign resolved   = alu(acc, pending, entry);

    always_comb begin
        acc_n     = acc;
        entry_n   = entry;
        pending_n = pending;
        disp_n    = display;
        case (ev.kind)
            KEY_DIGIT: begin
                entry_n = entry_base * DATA_W'(10) + DATA_W'(ev.digit);
                disp_n  = entry_n;
            end
            KEY_OP: begin
                if (ev.op == OP_NEG) begin
                    entry_n = -entry;       // sign change on entry only
                    disp_n  = entry_n;
                end else begin
                    acc_n     = resolved;   // left to right
                    pending_n = ev.op;
                    entry_n   = '0;
                    disp_n    = resolved;
                end
            end
            KEY_EQUAL: begin
                acc_n     = resolved;
                pending_n = OP_NONE;
                entry_n   = resolved;       // result becomes operand
                disp_n    = resolved;
            end
            KEY_CLEAR: begin
                acc_n     = '0;
                pending_n = OP_NONE;
                entry_n   = '0;
                disp_n    = '0;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state    <= READY;
            ev_ack   <= 1'b0;
            disp_req <= 1'b0;
            acc      <= '0;
            entry    <= '0;
            pending  <= OP_NONE;
            after_eq <= 1'b0;
            display  <= '0;
        end else begin
            if (ev_ack && !ev_req)
                ev_ack <= 1'b0;             // input side closes on its own
            case (state)
                READY: begin
                    if (accept) begin
                        acc      <= acc_n;
                        entry    <= entry_n;
                        pending  <= pending_n;
                        after_eq <= (ev.kind == KEY_EQUAL);
                        display  <= disp_n;
                        ev_ack   <= 1'b1;   // ack and offer in same cycle
                        disp_req <= 1'b1;
                        state    <= SHOW;
                    end
                end
                SHOW: begin
                    if (disp_ack) begin
                        disp_req <= 1'b0;
                        state    <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (!disp_ack)
                        state <= READY;
                end
                default: state <= READY;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/key_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module key_decoder import calc_pkg::*; (
    input  logic       clk,
    input  logic       nRST,
    input  logic       key_req,
    input  key_code_t  key_code,
    output logic       key_ack,
    output logic       ev_req,
    output key_event_t ev,
    input  logic       ev_ack
);

    logic full;   // buffer holds an event
    logic sent;   // core took it and ev_ack not yet low

    function automatic key_event_t map_key(input key_code_t code);
        key_event_t e;
        case (code)
            4'd0:  e = '{kind: KEY_DIGIT, digit: 4'd1, op: OP_NONE};
            4'd1:  e = '{kind: KEY_DIGIT, digit: 4'd2, op: OP_NONE};
            4'd2:  e = '{kind: KEY_DIGIT, digit: 4'd3, op: OP_NONE};
            4'd3:  e = '{kind: KEY_OP,    digit: 4'd0, op: OP_ADD};
            4'd4:  e = '{kind: KEY_DIGIT, digit: 4'd4, op: OP_NONE};
            4'd5:  e = '{kind: KEY_DIGIT, digit: 4'd5, op: OP_NONE};
            4'd6:  e = '{kind: KEY_DIGIT, digit: 4'd6, op: OP_NONE};
            4'd7:  e = '{kind: KEY_OP,    digit: 4'd0, op: OP_SUB};
            4'd8:  e = '{kind: KEY_DIGIT, digit: 4'd7, op: OP_NONE};
            4'd9:  e = '{kind: KEY_DIGIT, digit: 4'd8, op: OP_NONE};
            4'd10: e = '{kind: KEY_DIGIT, digit: 4'd9, op: OP_NONE};
            4'd11: e = '{kind: KEY_OP,    digit: 4'd0, op: OP_MUL};
            4'd12: e = '{kind: KEY_EQUAL, digit: 4'd0, op: OP_NONE};
            4'd13: e = '{kind: KEY_DIGIT, digit: 4'd0, op: OP_NONE};
            4'd14: e = '{kind: KEY_CLEAR, digit: 4'd0, op: OP_NONE}; // clear key
            4'd15: e = '{kind: KEY_OP,    digit: 4'd0, op: OP_NEG};
        endcase
        return e;
    endfunction

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            full    <= 1'b0;
            sent    <= 1'b0;
            key_ack <= 1'b0;
            ev_req  <= 1'b0;
        end else begin
            if (key_req && !key_ack && !full) begin
                key_ack <= 1'b1;              // capture only into an empty buffer
                full    <= 1'b1;
                ev      <= map_key(key_code);
            end else if (!key_req) begin
                key_ack <= 1'b0;
            end

            if (full && !sent && !ev_req)
                ev_req <= 1'b1;               // one cycle after key_ack
            if (ev_req && ev_ack) begin
                ev_req <= 1'b0;
                sent   <= 1'b1;
            end
            if (sent && !ev_ack) begin
                sent <= 1'b0;                 // four-phase done so the buffer frees
                full <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/keypad_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module keypad_scanner import calc_pkg::*; (
    input  logic       clk,
    input  logic       nRST,
    input  logic [3:0] row,        // active low, pulled up
    output logic [3:0] col,        // active low column drive
    output logic       key_req,
    input  logic       key_ack,
    output key_code_t  key_code
);

    typedef enum logic [2:0] {
        SCAN,
        DEBOUNCE,
        OFFER,
        RELEASE,
        RELEASE_DEBOUNCE
    } scan_state_e;

    scan_state_e          state;
    logic [1:0]           col_idx;    // column being driven
    logic [DEB_CNT_W-1:0] cnt;        // unchanged-read counter
    logic [3:0]           row_prev;   // last row sample while debouncing
    logic [1:0]           row_idx;    // lowest low row
    logic                 any_low;

    assign any_low = (row != 4'hF);

    // priority pick, lowest row wins on multi-press
    always_comb begin
        row_idx = 2'd0;
        for (int r = 3; r >= 0; r--) begin
            if (!row[r])
                row_idx = 2'(r);
        end
    end

    always_comb begin
        col = 4'b1111;
        col[col_idx] = 1'b0;       // one column low at a time
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state   <= SCAN;
            col_idx <= 2'd0;
            cnt     <= '0;
            key_req <= 1'b0;
        end else begin
            case (state)
                SCAN: begin
                    if (any_low) begin
                        state    <= DEBOUNCE;      // hold this column
                        cnt      <= '0;
                        row_prev <= row;
                    end else begin
                        col_idx <= col_idx + 2'd1; // next column, wraps
                    end
                end
                DEBOUNCE: begin
                    if (row != row_prev) begin
                        cnt      <= '0;            // bounce, restart count
                        row_prev <= row;
                    end else if (cnt != DEB_LAST) begin
                        cnt <= cnt + 1'b1;
                    end else if (!any_low) begin
                        state <= SCAN;             // settled open, false press
                    end else if (!key_ack) begin
                        key_code <= {row_idx, col_idx};
                        key_req  <= 1'b1;
                        state    <= OFFER;
                    end
                end
                OFFER: begin
                    if (key_ack) begin
                        key_req <= 1'b0;
                        state   <= RELEASE;
                    end
                end
                RELEASE: begin
                    if (!any_low) begin
                        cnt   <= '0;
                        state <= RELEASE_DEBOUNCE;
                    end
                end
                RELEASE_DEBOUNCE: begin
                    if (any_low) begin
                        state <= RELEASE;          // still bouncing or held
                    end else if (cnt != DEB_LAST) begin
                        cnt <= cnt + 1'b1;
                    end else if (!key_ack) begin
                        state <= SCAN;             // handshake closed, key up
                    end
                end
                default: state <= SCAN;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/calc_pkg.sv
`default_nettype none

package calc_pkg;

    localparam int DEBOUNCE_CYCLES = 10;                      // stable reads per press/release
    localparam int DEB_CNT_W = $clog2(DEBOUNCE_CYCLES);       // debounce counter width
    localparam logic [DEB_CNT_W-1:0] DEB_LAST = DEB_CNT_W'(DEBOUNCE_CYCLES - 1);

    localparam int DATA_W = 16;                               // signed data width

    typedef logic [3:0] key_code_t;                           // row*4 + col

    typedef enum logic [1:0] {
        KEY_DIGIT,
        KEY_OP,
        KEY_EQUAL,
        KEY_CLEAR
    } key_kind_e;

    // fixed operator encoding of the keypad controller
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_NEG  = 3'd1,                                       // sign change applied at once
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } op_e;

    typedef struct packed {
        key_kind_e  kind;                                     // 2 bits
        logic [3:0] digit;                                    // 0..9 on digit keys
        op_e        op;                                       // operator keys only
    } key_event_t;

endpackage

`default_nettype wire
